//--- design/umi_fifo_cfg.svh
// UMI FIFO configuration
// Global sizing shared by every FIFO block and both packages,
// plus the chaos LFSR setup for the write side
`ifndef UMI_FIFO_CFG_SVH
`define UMI_FIFO_CFG_SVH

//##########################################################
// FIFO geometry
//##########################################################

// Entries in the memory, power of two
`define UMI_FIFO_DEPTH 4
// log2 of the depth
`define UMI_FIFO_AW 2

//##########################################################
// UMI packet fields
//##########################################################

`define UMI_CMD_W 32
`define UMI_ADDR_W 64
`define UMI_DATA_W 96

//##########################################################
// Chaos LFSR
//##########################################################

`define UMI_FIFO_LFSR_W 16
// Nonzero start value; low bits chosen so no veto right after reset
`define UMI_FIFO_LFSR_SEED 16'hACE1
// Galois taps for x^16 + x^14 + x^13 + x^11, maximal length
`define UMI_FIFO_LFSR_TAPS 16'hB400
// Veto when all these bits are set, about one cycle in four
`define UMI_FIFO_CHAOS_MASK 16'h0005

`endif

//--- design/umi_pkg.sv
// UMI packet types
// Field widths and the packed 256-bit packet used on both FIFO ports

`default_nettype none

`include "umi_fifo_cfg.svh"

package umi_pkg;

   //##########################################################
   // Field types
   //##########################################################

   // Command word, opcode and size live here
   typedef logic [`UMI_CMD_W-1:0] umi_cmd_t;

   // Destination and source address share this type
   typedef logic [`UMI_ADDR_W-1:0] umi_addr_t;

   // Payload
   typedef logic [`UMI_DATA_W-1:0] umi_data_t;

   //##########################################################
   // Packet
   //##########################################################

   // First member is the MSB, so cmd ends up in bits [31:0]
   // Layout: data[255:160] srcaddr[159:96] dstaddr[95:32] cmd[31:0]
   typedef struct packed {
      umi_data_t data;
      umi_addr_t srcaddr;
      umi_addr_t dstaddr;
      umi_cmd_t  cmd;
   } umi_packet_t;

endpackage

`default_nettype wire

//--- design/fifo_pkg.sv
// FIFO internal types
// Address and pointer widths for the dual-clock FIFO, the chaos LFSR
// word and the read-side output register states

`default_nettype none

`include "umi_fifo_cfg.svh"

package fifo_pkg;

   //##########################################################
   // Pointers
   //##########################################################

   // Memory index
   typedef logic [`UMI_FIFO_AW-1:0] fifo_addr_t;

   // Extra MSB is the wrap bit
   // Same type carries binary and gray encodings
   typedef logic [`UMI_FIFO_AW:0] fifo_ptr_t;

   // Chaos generator state
   typedef logic [`UMI_FIFO_LFSR_W-1:0] fifo_lfsr_t;

   //##########################################################
   // Read side FSM
   //##########################################################

   // Output register occupancy
   typedef enum logic [0:0] {
      RD_EMPTY = 1'b0,
      RD_VALID = 1'b1
   } rd_state_t;

endpackage

`default_nettype wire

//--- design/fifo_mem.sv
// FIFO storage array
// Written on the in-clock, read asynchronously by address from the
// out-clock side; entries are only read once the pointer has crossed

`default_nettype none

`include "umi_fifo_cfg.svh"

module fifo_mem (
   input  wire                       umi_in_clk,
   input  wire                       wr_en,
   input  wire fifo_pkg::fifo_addr_t wr_addr,
   input  wire umi_pkg::umi_packet_t wr_data,
   input  wire fifo_pkg::fifo_addr_t rd_addr,
   output umi_pkg::umi_packet_t      rd_data
);

   //##########################################################
   // Storage
   //##########################################################

   umi_pkg::umi_packet_t mem [0:`UMI_FIFO_DEPTH-1];

   // Write port, in-clock domain
   always_ff @(posedge umi_in_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   //##########################################################
   // Read port
   //##########################################################

   // Plain mux by address
   // Read controller registers the result
   assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- design/fifo_wr_ctrl.sv
// FIFO write controller
// Binary and gray write pointer, read pointer synchronizer, full flag
// and a chaos LFSR that can withdraw readiness on random cycles

`default_nettype none

`include "umi_fifo_cfg.svh"

module fifo_wr_ctrl (
   input  wire                      umi_in_clk,
   input  wire                      umi_in_nreset,
   input  wire                      wr_valid,
   input  wire                      chaosmode,
   input  wire fifo_pkg::fifo_ptr_t rd_ptr_gray,
   output logic                     wr_ready,
   output logic                     wr_en,
   output logic                     wr_full,
   output fifo_pkg::fifo_addr_t     wr_addr,
   output fifo_pkg::fifo_ptr_t      wr_ptr_gray
);

   fifo_pkg::fifo_ptr_t  wr_ptr_bin;
   fifo_pkg::fifo_ptr_t  wr_ptr_bin_next;
   fifo_pkg::fifo_ptr_t  wr_ptr_gray_next;
   fifo_pkg::fifo_ptr_t  rd_ptr_sync1;
   fifo_pkg::fifo_ptr_t  rd_ptr_sync2;
   fifo_pkg::fifo_ptr_t  rd_ptr_full_cmp;
   fifo_pkg::fifo_lfsr_t lfsr;
   logic                 chaos_veto;

   //##########################################################
   // Read pointer crossing
   //##########################################################

   // Two flop synchronizer, gray code so at most one bit moves
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset) begin
      if (!umi_in_nreset) begin
         rd_ptr_sync1 <= '0;
         rd_ptr_sync2 <= '0;
      end else begin
         rd_ptr_sync1 <= rd_ptr_gray;
         rd_ptr_sync2 <= rd_ptr_sync1;
      end
   end

   //##########################################################
   // Chaos generator
   //##########################################################

   // Galois form, shifts right every cycle regardless of mode
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset) begin
      if (!umi_in_nreset) begin
         lfsr <= `UMI_FIFO_LFSR_SEED;
      end else begin
         lfsr <= (lfsr >> 1) ^ (lfsr[0] ? fifo_pkg::fifo_lfsr_t'(`UMI_FIFO_LFSR_TAPS) : '0);
      end
   end

   // Only bites in chaos mode
   assign chaos_veto = chaosmode & ((lfsr & `UMI_FIFO_CHAOS_MASK) == `UMI_FIFO_CHAOS_MASK);

   //##########################################################
   // Handshake and pointer
   //##########################################################

   // Full always wins over the veto
   assign wr_ready = ~wr_full & ~chaos_veto;
   assign wr_en    = wr_valid & wr_ready;
   assign wr_addr  = wr_ptr_bin[`UMI_FIFO_AW-1:0];

   assign wr_ptr_bin_next  = wr_ptr_bin + fifo_pkg::fifo_ptr_t'(wr_en);
   assign wr_ptr_gray_next = wr_ptr_bin_next ^ (wr_ptr_bin_next >> 1);

   // Full in gray space: top two bits flipped, rest equal
   assign rd_ptr_full_cmp = {~rd_ptr_sync2[`UMI_FIFO_AW:`UMI_FIFO_AW-1],
                             rd_ptr_sync2[`UMI_FIFO_AW-2:0]};

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset) begin
      if (!umi_in_nreset) begin
         wr_ptr_bin  <= '0;
         wr_ptr_gray <= '0;
         wr_full     <= 1'b0;
      end else begin
         wr_ptr_bin  <= wr_ptr_bin_next;
         wr_ptr_gray <= wr_ptr_gray_next;
         // Looks ahead at the new pointer, set on the filling write
         wr_full     <= (wr_ptr_gray_next == rd_ptr_full_cmp);
      end
   end

endmodule

`default_nettype wire

//--- design/fifo_rd_ctrl.sv
// FIFO read controller
// Write pointer synchronizer, empty flag, read pointer and the
// registered output stage with its two-state occupancy FSM

`default_nettype none

`include "umi_fifo_cfg.svh"

module fifo_rd_ctrl (
   input  wire                       umi_out_clk,
   input  wire                       umi_out_nreset,
   input  wire                       out_ready,
   input  wire fifo_pkg::fifo_ptr_t  wr_ptr_gray,
   input  wire umi_pkg::umi_packet_t rd_data,
   output fifo_pkg::fifo_addr_t      rd_addr,
   output fifo_pkg::fifo_ptr_t       rd_ptr_gray,
   output logic                      rd_empty,
   output logic                      out_valid,
   output umi_pkg::umi_packet_t      out_packet
);

   fifo_pkg::fifo_ptr_t   rd_ptr_bin;
   fifo_pkg::fifo_ptr_t   rd_ptr_bin_next;
   fifo_pkg::fifo_ptr_t   rd_ptr_gray_next;
   fifo_pkg::fifo_ptr_t   wr_ptr_sync1;
   fifo_pkg::fifo_ptr_t   wr_ptr_sync2;
   fifo_pkg::rd_state_t   rd_state;
   fifo_pkg::rd_state_t   rd_state_next;
   logic                  load;
   logic                  take;

   //##########################################################
   // Write pointer crossing
   //##########################################################

   always_ff @(posedge umi_out_clk or negedge umi_out_nreset) begin
      if (!umi_out_nreset) begin
         wr_ptr_sync1 <= '0;
         wr_ptr_sync2 <= '0;
      end else begin
         wr_ptr_sync1 <= wr_ptr_gray;
         wr_ptr_sync2 <= wr_ptr_sync1;
      end
   end

   //##########################################################
   // Output stage control
   //##########################################################

   // Consumer takes the held packet
   assign take = (rd_state == fifo_pkg::RD_VALID) & out_ready;
   // Refill when register is free or freeing up, and memory has data
   assign load = ~rd_empty & ((rd_state == fifo_pkg::RD_EMPTY) | out_ready);

   always_comb begin
      rd_state_next = rd_state;
      unique case (rd_state)
         fifo_pkg::RD_EMPTY: begin
            if (load) begin
               rd_state_next = fifo_pkg::RD_VALID;
            end
         end
         fifo_pkg::RD_VALID: begin
            // Take with a refill stays put
            if (take && !load) begin
               rd_state_next = fifo_pkg::RD_EMPTY;
            end
         end
         default: rd_state_next = fifo_pkg::RD_EMPTY;
      endcase
   end

   assign out_valid = (rd_state == fifo_pkg::RD_VALID);

   //##########################################################
   // Read pointer and flags
   //##########################################################

   assign rd_addr          = rd_ptr_bin[`UMI_FIFO_AW-1:0];
   assign rd_ptr_bin_next  = rd_ptr_bin + fifo_pkg::fifo_ptr_t'(load);
   assign rd_ptr_gray_next = rd_ptr_bin_next ^ (rd_ptr_bin_next >> 1);

   always_ff @(posedge umi_out_clk or negedge umi_out_nreset) begin
      if (!umi_out_nreset) begin
         rd_state    <= fifo_pkg::RD_EMPTY;
         rd_ptr_bin  <= '0;
         rd_ptr_gray <= '0;
         rd_empty    <= 1'b1;
      end else begin
         rd_state    <= rd_state_next;
         rd_ptr_bin  <= rd_ptr_bin_next;
         rd_ptr_gray <= rd_ptr_gray_next;
         // Empty once read side catches up with the synced writer
         rd_empty    <= (rd_ptr_gray_next == wr_ptr_sync2);
      end
   end

   // Payload register, holds still under back-pressure
   always_ff @(posedge umi_out_clk) begin
      if (load) begin
         out_packet <= rd_data;
      end
   end

endmodule

`default_nettype wire

//--- design/umi_fifo.sv
// UMI dual-clock packet FIFO
// Write controller, storage and registered read side, plus a static
// bypass path from input straight to output

`default_nettype none

module umi_fifo (
   input  wire                       bypass,
   input  wire                       chaosmode,
   output logic                      fifo_full,
   output logic                      fifo_empty,
   // Input side
   input  wire                       umi_in_clk,
   input  wire                       umi_in_nreset,
   input  wire                       umi_in_valid,
   input  wire umi_pkg::umi_packet_t umi_in_packet,
   output logic                      umi_in_ready,
   // Output side
   input  wire                       umi_out_clk,
   input  wire                       umi_out_nreset,
   output logic                      umi_out_valid,
   output umi_pkg::umi_packet_t      umi_out_packet,
   input  wire                       umi_out_ready
);

   logic                 fifo_wr_valid;
   logic                 fifo_in_ready;
   logic                 fifo_wr_en;
   logic                 fifo_out_ready;
   logic                 fifo_out_valid;
   fifo_pkg::fifo_addr_t wr_addr;
   fifo_pkg::fifo_addr_t rd_addr;
   fifo_pkg::fifo_ptr_t  wr_ptr_gray;
   fifo_pkg::fifo_ptr_t  rd_ptr_gray;
   umi_pkg::umi_packet_t rd_data;
   umi_pkg::umi_packet_t fifo_out_packet;

   //##########################################################
   // FIFO path
   //##########################################################

   // No writes while bypassed
   assign fifo_wr_valid  = umi_in_valid & ~bypass;
   assign fifo_out_ready = umi_out_ready & ~bypass;

   fifo_wr_ctrl u_wr_ctrl (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .wr_valid      (fifo_wr_valid),
      .chaosmode     (chaosmode),
      .rd_ptr_gray   (rd_ptr_gray),
      .wr_ready      (fifo_in_ready),
      .wr_en         (fifo_wr_en),
      .wr_full       (fifo_full),
      .wr_addr       (wr_addr),
      .wr_ptr_gray   (wr_ptr_gray)
   );

   fifo_mem u_mem (
      .umi_in_clk (umi_in_clk),
      .wr_en      (fifo_wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (umi_in_packet),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .umi_out_clk    (umi_out_clk),
      .umi_out_nreset (umi_out_nreset),
      .out_ready      (fifo_out_ready),
      .wr_ptr_gray    (wr_ptr_gray),
      .rd_data        (rd_data),
      .rd_addr        (rd_addr),
      .rd_ptr_gray    (rd_ptr_gray),
      .rd_empty       (fifo_empty),
      .out_valid      (fifo_out_valid),
      .out_packet     (fifo_out_packet)
   );

   //##########################################################
   // Bypass select
   //##########################################################

   // Static select, only valid with equal clocks and drained FIFO
   assign umi_out_packet = bypass ? umi_in_packet : fifo_out_packet;
   assign umi_out_valid  = bypass ? umi_in_valid : fifo_out_valid;
   assign umi_in_ready   = bypass ? umi_out_ready : fifo_in_ready;

endmodule

`default_nettype wire

//--- verification/umi_fifo_checker.sv
// UMI FIFO checker
// Watches the DUT ports, keeps a log of accepted packets and compares
// every taken packet, plus back-pressure, capacity and bypass checks

`default_nettype none

`include "umi_fifo_cfg.svh"

module umi_fifo_checker (
   input  wire                       umi_in_clk,
   input  wire                       umi_in_nreset,
   input  wire                       umi_out_clk,
   input  wire                       umi_out_nreset,
   input  wire                       bypass,
   input  wire                       chaosmode,
   input  wire                       fifo_full,
   input  wire                       fifo_empty,
   input  wire                       umi_in_valid,
   input  wire                       umi_in_ready,
   input  wire umi_pkg::umi_packet_t umi_in_packet,
   input  wire                       umi_out_valid,
   input  wire                       umi_out_ready,
   input  wire umi_pkg::umi_packet_t umi_out_packet,
   input  wire [7:0]                 test_id,
   input  wire [1:0]                 test_duty,
   input  wire                       test_end,
   output int                        pending,
   output int                        error_count,
   output int                        tests_run
);

   umi_pkg::umi_packet_t accepted_log [0:1023];
   umi_pkg::umi_packet_t prev_packet;
   int                   acc_count = 0;
   int                   take_count = 0;
   int                   full_hits = 0;
   int                   veto_hits = 0;
   int                   full_snap = 0;
   int                   veto_snap = 0;
   int                   err_snap = 0;
   int                   acc_snap = 0;
   int                   err_in = 0;
   int                   err_out = 0;
   int                   err_byp = 0;
   bit                   stall_prev = 0;
   bit                   reset_checked = 0;

   assign pending     = acc_count - take_count;
   assign error_count = err_in + err_out + err_byp;

   //############################################################
   // Input side
   //############################################################

   always @(posedge umi_in_clk) begin
      if (umi_in_nreset) begin
         if (fifo_full) full_hits++;
         // Ready withdrawn without full, only chaos does that
         if (!bypass && !umi_in_ready && !fifo_full) veto_hits++;
         if (!bypass && !chaosmode && umi_in_valid && !umi_in_ready && !fifo_full) begin
            $display("Input stalled while fifo_full was low in test %0d", test_id);
            err_in++;
         end
         if (!bypass && umi_in_valid && umi_in_ready) begin
            accepted_log[acc_count % 1024] = umi_in_packet;
            acc_count++;
         end
      end
   end

   //############################################################
   // Output side
   //############################################################

   always @(posedge umi_out_clk) begin
      if (umi_out_nreset) begin
         // First edge out of reset, nothing written yet
         if (!reset_checked) begin
            if (umi_out_valid !== 1'b0) begin
               $display("[ERROR] umi_out_valid expected 0 got %h", umi_out_valid);
               err_out++;
            end
            if (fifo_empty !== 1'b1) begin
               $display("[ERROR] fifo_empty expected 1 got %h", fifo_empty);
               err_out++;
            end
            $display("test 0 (reset) finished: %0d errors", error_count);
            reset_checked = 1;
            err_snap = err_in + err_out + err_byp;
            tests_run++;
         end
         if (!bypass) begin
            // Held packet must not move under back-pressure
            if (stall_prev) begin
               if (umi_out_valid !== 1'b1) begin
                  $display("[ERROR] umi_out_valid expected 1 got %h", umi_out_valid);
                  err_out++;
               end else if (umi_out_packet !== prev_packet) begin
                  $display("[ERROR] umi_out_packet expected %h got %h",
                           prev_packet, umi_out_packet);
                  err_out++;
               end
            end
            if (umi_out_valid && umi_out_ready) begin
               if (take_count >= acc_count) begin
                  $display("Packet taken at output with none accepted at input");
                  err_out++;
               end else begin
                  if (umi_out_packet !== accepted_log[take_count % 1024]) begin
                     $display("[ERROR] umi_out_packet expected %h got %h",
                              accepted_log[take_count % 1024], umi_out_packet);
                     err_out++;
                  end
                  take_count++;
               end
            end
            if (acc_count - take_count > `UMI_FIFO_DEPTH + 1) begin
               $display("More packets accepted than the FIFO can hold");
               err_out++;
            end
         end
         stall_prev  = !bypass && umi_out_valid && !umi_out_ready;
         prev_packet = umi_out_packet;

         // End of test summary
         if (test_end) begin
            if (test_duty == 2'd2 && full_hits == full_snap) begin
               $display("fifo_full never went high in test %0d", test_id);
               err_out++;
            end
            if (chaosmode && veto_hits == veto_snap) begin
               $display("Chaos mode never withdrew ready in test %0d", test_id);
               err_out++;
            end
            if (!bypass && take_count != acc_count) begin
               $display("Packets left undelivered in test %0d", test_id);
               err_out++;
            end
            $display("test %0d finished: %0d packets, %0d errors", test_id,
                     acc_count - acc_snap, err_in + err_out + err_byp - err_snap);
            full_snap = full_hits;
            veto_snap = veto_hits;
            acc_snap  = acc_count;
            err_snap  = err_in + err_out + err_byp;
            tests_run++;
         end
      end
   end

   //############################################################
   // Bypass path
   //############################################################

   // Mid-cycle sample, all inputs settle on rising edges
   always @(negedge umi_out_clk) begin
      if (umi_out_nreset && bypass) begin
         if (umi_out_packet !== umi_in_packet) begin
            $display("[ERROR] umi_out_packet expected %h got %h", umi_in_packet, umi_out_packet);
            err_byp++;
         end
         if (umi_out_valid !== umi_in_valid) begin
            $display("[ERROR] umi_out_valid expected %h got %h", umi_in_valid, umi_out_valid);
            err_byp++;
         end
         if (umi_in_ready !== umi_out_ready) begin
            $display("[ERROR] umi_in_ready expected %h got %h", umi_out_ready, umi_in_ready);
            err_byp++;
         end
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_umi_fifo.sv
// UMI FIFO testbench
// Clocks, reset, vector file reading, packet stimulus, output ready
// patterns, watchdog and the closing summary

`default_nettype none

module tb_umi_fifo;

   typedef struct packed {
      logic [7:0]           test;
      logic                 bypass;
      logic                 chaos;
      logic [1:0]           duty;
      umi_pkg::umi_packet_t packet;
   } vector_t;

   logic                 umi_out_clk = 1'b0;
   logic                 umi_in_clk = 1'b0;
   logic                 umi_in_nreset;
   logic                 umi_out_nreset;
   logic                 bypass;
   logic                 chaosmode;
   logic                 umi_in_valid;
   umi_pkg::umi_packet_t umi_in_packet;
   logic                 umi_in_ready;
   logic                 umi_out_valid;
   umi_pkg::umi_packet_t umi_out_packet;
   logic                 umi_out_ready;
   logic                 fifo_full;
   logic                 fifo_empty;
   logic [7:0]           test_id;
   logic [1:0]           duty;
   logic                 hold_low;
   logic                 test_end;
   bit                   clk_same = 0;
   bit                   loaded = 0;
   int                   pending;
   int                   error_count;
   int                   tests_run;
   vector_t              vectors[$];
   time                  limit;

   //############################################################
   // Clocks
   //############################################################

   always #50 umi_out_clk = ~umi_out_clk;

   // Own 70 unit clock, or a copy of the out clock for bypass
   always begin
      if (clk_same) begin
         @(umi_out_clk);
         umi_in_clk = umi_out_clk;
      end else begin
         #35;
         umi_in_clk = ~umi_in_clk;
      end
   end

   umi_fifo dut (
      .bypass         (bypass),
      .chaosmode      (chaosmode),
      .fifo_full      (fifo_full),
      .fifo_empty     (fifo_empty),
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_in_valid   (umi_in_valid),
      .umi_in_packet  (umi_in_packet),
      .umi_in_ready   (umi_in_ready),
      .umi_out_clk    (umi_out_clk),
      .umi_out_nreset (umi_out_nreset),
      .umi_out_valid  (umi_out_valid),
      .umi_out_packet (umi_out_packet),
      .umi_out_ready  (umi_out_ready)
   );

   umi_fifo_checker chk (
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_out_clk    (umi_out_clk),
      .umi_out_nreset (umi_out_nreset),
      .bypass         (bypass),
      .chaosmode      (chaosmode),
      .fifo_full      (fifo_full),
      .fifo_empty     (fifo_empty),
      .umi_in_valid   (umi_in_valid),
      .umi_in_ready   (umi_in_ready),
      .umi_in_packet  (umi_in_packet),
      .umi_out_valid  (umi_out_valid),
      .umi_out_ready  (umi_out_ready),
      .umi_out_packet (umi_out_packet),
      .test_id        (test_id),
      .test_duty      (duty),
      .test_end       (test_end),
      .pending        (pending),
      .error_count    (error_count),
      .tests_run      (tests_run)
   );

   // Duty 0 always ready, 1 random, 2 low until the input stalls
   // Seeded here since this process draws the random ready values
   initial begin
      void'($urandom(32'h617f));
      forever begin
         @(posedge umi_out_clk);
         case (duty)
            2'd0: umi_out_ready <= 1'b1;
            2'd1: umi_out_ready <= (($urandom % 2) == 1);
            default: umi_out_ready <= !hold_low;
         endcase
      end
   end

   //############################################################
   // Tasks
   //############################################################

   // Called on a rising in-clock edge, returns on the accepting edge
   task automatic send_packet(input umi_pkg::umi_packet_t pkt);
      int stall;
      bit accepted;
      begin
         stall = 0;
         accepted = 0;
         umi_in_valid  <= 1'b1;
         umi_in_packet <= pkt;
         while (!accepted) begin
            @(posedge umi_in_clk);
            if (umi_in_ready) begin
               accepted = 1;
            end else begin
               stall++;
               if (stall >= 20) hold_low <= 1'b0;
            end
         end
      end
   endtask

   // Sampled mid-cycle, gives up after 100 out-clock cycles
   task automatic drain_and_close();
      int waited;
      begin
         waited = 0;
         @(negedge umi_out_clk);
         while (waited < 100 && (pending != 0 || umi_out_valid)) begin
            @(negedge umi_out_clk);
            waited++;
         end
         @(posedge umi_out_clk);
         test_end <= 1'b1;
         @(posedge umi_out_clk);
         test_end <= 1'b0;
      end
   endtask

   //############################################################
   // Main sequence
   //############################################################

   initial begin
      int fd;
      int rc;
      int idx;
      int t;
      int b;
      int c;
      int d;
      string line;
      umi_pkg::umi_packet_t p;
      vector_t cur;
      umi_in_nreset  = 1'b0;
      umi_out_nreset = 1'b0;
      bypass         = 1'b0;
      chaosmode      = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_packet  = '0;
      umi_out_ready  = 1'b0;
      test_id        = 8'd0;
      duty           = 2'd0;
      hold_low       = 1'b0;
      test_end       = 1'b0;
      fd = $fopen("verification/umi_fifo_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file");
         $display("Test failures found");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() < 4 || line.substr(0, 1) == "//") continue;
            rc = $sscanf(line, "%d %d %d %d %h", t, b, c, d, p);
            if (rc == 5) vectors.push_back({t[7:0], b[0], c[0], d[1:0], p});
         end
         $fclose(fd);
         limit = (vectors.size() + 2) * 200 * 100;
         loaded = 1;
         repeat (4) @(posedge umi_out_clk);
         umi_in_nreset  <= 1'b1;
         umi_out_nreset <= 1'b1;
         repeat (3) @(posedge umi_out_clk);
         idx = 0;
         while (idx < vectors.size()) begin
            cur = vectors[idx];
            @(posedge umi_out_clk);
            clk_same = cur.bypass;
            bypass    <= cur.bypass;
            chaosmode <= cur.chaos;
            duty      <= cur.duty;
            hold_low  <= (cur.duty == 2'd2);
            test_id   <= cur.test;
            repeat (2) @(posedge umi_out_clk);
            @(posedge umi_in_clk);
            while (idx < vectors.size() && vectors[idx].test == cur.test) begin
               send_packet(vectors[idx].packet);
               idx++;
            end
            umi_in_valid <= 1'b0;
            drain_and_close();
         end
         repeat (2) @(posedge umi_out_clk);
         $display("Summary: %0d tests, %0d errors", tests_run, error_count);
         if (error_count == 0) begin
            $display("All tests passed!");
         end else begin
            $display("Test failures found");
         end
         $finish;
      end
   end

   // Watchdog allows 200 out-clock cycles per vector line
   initial begin
      wait (loaded);
      #(limit);
      $display("Run stopped after %0t time units without finishing", limit);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/umi_fifo_input.txt
// test bypass chaos duty(0 ready,1 random,2 held low) packet(256-bit hex)
// packet = data[255:160] srcaddr[159:96] dstaddr[95:32] cmd[31:0]
1 0 0 0 a1100001b1100002c1100003d1100004e1100005f110000691100007811000a8
1 0 0 0 a1200001b1200002c1200003d1200004e1200005f120000691200007812000a8
1 0 0 0 a1300001b1300002c1300003d1300004e1300005f130000691300007813000a8
1 0 0 0 a1400001b1400002c1400003d1400004e1400005f140000691400007814000a8
1 0 0 0 a1500001b1500002c1500003d1500004e1500005f150000691500007815000a8
1 0 0 0 a1600001b1600002c1600003d1600004e1600005f160000691600007816000a8
2 0 0 1 a2100001b2100002c2100003d2100004e2100005f210000692100007821000a8
2 0 0 1 a2200001b2200002c2200003d2200004e2200005f220000692200007822000a8
2 0 0 1 a2300001b2300002c2300003d2300004e2300005f230000692300007823000a8
2 0 0 1 a2400001b2400002c2400003d2400004e2400005f240000692400007824000a8
2 0 0 1 a2500001b2500002c2500003d2500004e2500005f250000692500007825000a8
2 0 0 1 a2600001b2600002c2600003d2600004e2600005f260000692600007826000a8
3 0 0 2 a3100001b3100002c3100003d3100004e3100005f310000693100007831000a8
3 0 0 2 a3200001b3200002c3200003d3200004e3200005f320000693200007832000a8
3 0 0 2 a3300001b3300002c3300003d3300004e3300005f330000693300007833000a8
3 0 0 2 a3400001b3400002c3400003d3400004e3400005f340000693400007834000a8
3 0 0 2 a3500001b3500002c3500003d3500004e3500005f350000693500007835000a8
3 0 0 2 a3600001b3600002c3600003d3600004e3600005f360000693600007836000a8
3 0 0 2 a3700001b3700002c3700003d3700004e3700005f370000693700007837000a8
3 0 0 2 a3800001b3800002c3800003d3800004e3800005f380000693800007838000a8
4 0 1 1 a4100001b4100002c4100003d4100004e4100005f410000694100007841000a8
4 0 1 1 a4200001b4200002c4200003d4200004e4200005f420000694200007842000a8
4 0 1 1 a4300001b4300002c4300003d4300004e4300005f430000694300007843000a8
4 0 1 1 a4400001b4400002c4400003d4400004e4400005f440000694400007844000a8
4 0 1 1 a4500001b4500002c4500003d4500004e4500005f450000694500007845000a8
4 0 1 1 a4600001b4600002c4600003d4600004e4600005f460000694600007846000a8
4 0 1 1 a4700001b4700002c4700003d4700004e4700005f470000694700007847000a8
4 0 1 1 a4800001b4800002c4800003d4800004e4800005f480000694800007848000a8
5 1 0 1 a5100001b5100002c5100003d5100004e5100005f510000695100007851000a8
5 1 0 1 a5200001b5200002c5200003d5200004e5200005f520000695200007852000a8
5 1 0 1 a5300001b5300002c5300003d5300004e5300005f530000695300007853000a8
5 1 0 1 a5400001b5400002c5400003d5400004e5400005f540000695400007854000a8

//--- filelist.f
+incdir+design
design/umi_pkg.sv
design/fifo_pkg.sv
design/fifo_mem.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/umi_fifo.sv
verification/umi_fifo_checker.sv
verification/tb_umi_fifo.sv
